/* rtl/dcache_pkg.sv */
package dcache_pkg;

    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int LINE_W     = 128;
    localparam int NWAY       = 2;
    localparam int NSET       = 256;
    localparam int SET_W      = 8;
    localparam int TAG_W      = 20;
    localparam int WORD_SEL_W = 2;     // addr[3:2]
    localparam int STRB_W     = 4;
    localparam int BYTE_W     = 8;
    localparam int OFFSET_W   = 4;     // byte offset inside a line
    localparam int WORD_LSB   = 2;

    localparam int LFSR_W = 16;
    localparam logic [LFSR_W-1:0] LFSR_SEED = 16'hace1;   // any nonzero value

    localparam logic [SET_W-1:0] LAST_SET = SET_W'(NSET - 1);

    typedef logic [LINE_W-1:0] line_t;
    typedef logic [$clog2(NWAY)-1:0] way_t;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic              write;   // 1 store, 0 load
        logic [ADDR_W-1:0] addr;
        logic [STRB_W-1:0] wstrb;
        logic [WORD_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;    // line aligned
        line_t             line;
    } mem_wr_t;

    // address field helpers
    function automatic logic [TAG_W-1:0] addr_tag(input logic [ADDR_W-1:0] a);
        return a[OFFSET_W+SET_W +: TAG_W];
    endfunction

    function automatic logic [SET_W-1:0] addr_set(input logic [ADDR_W-1:0] a);
        return a[OFFSET_W +: SET_W];
    endfunction

    function automatic logic [WORD_SEL_W-1:0] addr_word(input logic [ADDR_W-1:0] a);
        return a[WORD_LSB +: WORD_SEL_W];
    endfunction

    function automatic logic [ADDR_W-1:0] line_base(input logic [TAG_W-1:0] tag,
                                                    input logic [SET_W-1:0] set);
        return {tag, set, {OFFSET_W{1'b0}}};
    endfunction

endpackage

/* rtl/cache_ram.sv */
module cache_ram #(
    parameter type entry_t = dcache_pkg::line_t
) (
    input  logic                         clk,
    input  logic                         en_i,
    input  logic                         we_i,
    input  logic [dcache_pkg::SET_W-1:0] addr_i,
    input  entry_t                       wdata_i,
    output entry_t                       rdata_o
);

    entry_t mem [dcache_pkg::NSET];

    // single port, read returns the old entry on a write cycle
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end
            rdata_o <= mem[addr_i];
        end
    end

endmodule

/* rtl/victim_lfsr.sv */
module victim_lfsr (
    input  logic             clk,
    input  logic             rst,
    output dcache_pkg::way_t victim_o
);

    logic [dcache_pkg::LFSR_W-1:0] lfsr_q;
    logic                          fb;

    // x^16 + x^14 + x^13 + x^11 + 1, maximal length
    assign fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= dcache_pkg::LFSR_SEED;
        end else begin
            lfsr_q <= {lfsr_q[dcache_pkg::LFSR_W-2:0], fb};   // free running
        end
    end

    // low bit picks the way to replace
    assign victim_o = lfsr_q[0];

endmodule

/* rtl/way_match.sv */
module way_match (
    input  dcache_pkg::tag_entry_t [dcache_pkg::NWAY-1:0] tags_i,
    input  dcache_pkg::line_t      [dcache_pkg::NWAY-1:0] lines_i,
    input  logic [dcache_pkg::TAG_W-1:0]                  req_tag_i,
    input  dcache_pkg::way_t                              victim_i,

    output logic                                          hit_o,
    output dcache_pkg::way_t                              hit_way_o,
    output dcache_pkg::line_t                             hit_line_o,
    output logic                                          victim_dirty_o,
    output logic [dcache_pkg::TAG_W-1:0]                  victim_tag_o,
    output dcache_pkg::line_t                             victim_line_o
);

    logic [dcache_pkg::NWAY-1:0] way_hit;

    // per-way compare
    always_comb begin
        for (int w = 0; w < dcache_pkg::NWAY; w++) begin
            way_hit[w] = tags_i[w].valid && (tags_i[w].tag == req_tag_i);
        end
    end

    // at most one way can match, so the encode is plain
    always_comb begin
        hit_way_o = '0;
        for (int w = 0; w < dcache_pkg::NWAY; w++) begin
            if (way_hit[w]) begin
                hit_way_o = dcache_pkg::way_t'(w);
            end
        end
    end

    assign hit_o      = |way_hit;
    assign hit_line_o = lines_i[hit_way_o];

    // victim side, used for the write-back on a miss
    assign victim_dirty_o = tags_i[victim_i].valid & tags_i[victim_i].dirty;
    assign victim_tag_o   = tags_i[victim_i].tag;
    assign victim_line_o  = lines_i[victim_i];

endmodule

/* rtl/line_merge.sv */
module line_merge (
    input  dcache_pkg::line_t                 line_i,
    input  logic [dcache_pkg::WORD_SEL_W-1:0] word_sel_i,
    input  logic [dcache_pkg::STRB_W-1:0]     wstrb_i,
    input  logic [dcache_pkg::WORD_W-1:0]     wdata_i,
    output dcache_pkg::line_t                 line_o,
    output logic [dcache_pkg::WORD_W-1:0]     word_o
);

    // bit position of the selected word inside the line
    logic [$clog2(dcache_pkg::LINE_W)-1:0] word_base;

    assign word_base = {word_sel_i, {$clog2(dcache_pkg::WORD_W){1'b0}}};

    // load result, taken before the merge
    assign word_o = line_i[word_base +: dcache_pkg::WORD_W];

    always_comb begin
        line_o = line_i;
        for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
            if (wstrb_i[b]) begin
                line_o[word_base + b * dcache_pkg::BYTE_W +: dcache_pkg::BYTE_W] =
                    wdata_i[b * dcache_pkg::BYTE_W +: dcache_pkg::BYTE_W];
            end
        end
    end

endmodule

/* rtl/dcache_ctrl.sv */
module dcache_ctrl (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          req_valid_i,
    input  dcache_pkg::cpu_req_t          req_i,
    output logic                          ready_o,

    input  logic                          hit_i,
    input  dcache_pkg::way_t              hit_way_i,
    input  dcache_pkg::way_t              victim_i,
    input  logic                          victim_dirty_i,
    input  logic [dcache_pkg::TAG_W-1:0]  victim_tag_i,
    input  dcache_pkg::line_t             victim_line_i,
    input  dcache_pkg::line_t             hit_merged_i,
    input  dcache_pkg::line_t             ret_merged_i,
    input  logic [dcache_pkg::WORD_W-1:0] hit_word_i,
    input  logic [dcache_pkg::WORD_W-1:0] ret_word_i,

    input  logic                          mem_ret_valid_i,
    input  dcache_pkg::line_t             mem_ret_line_i,

    output logic                          ram_en_o,
    output logic [dcache_pkg::SET_W-1:0]  ram_addr_o,
    output logic [dcache_pkg::NWAY-1:0]   tag_we_o,
    output logic [dcache_pkg::NWAY-1:0]   data_we_o,
    output dcache_pkg::tag_entry_t        tag_wdata_o,
    output dcache_pkg::line_t             data_wdata_o,

    output dcache_pkg::cpu_req_t          req_o,
    output logic                          done_o,
    output logic [dcache_pkg::WORD_W-1:0] rdata_o,

    output logic                          mem_rd_o,
    output logic [dcache_pkg::ADDR_W-1:0] mem_rd_addr_o,
    output logic                          mem_wr_o,
    output dcache_pkg::mem_wr_t           mem_wr_data_o
);

    typedef enum logic [1:0] {
        ST_CLEAR,
        ST_IDLE,
        ST_LOOKUP,
        ST_REFILL
    } state_t;

    state_t                       state;
    logic [dcache_pkg::SET_W-1:0] clr_cnt;
    dcache_pkg::cpu_req_t         req_r;
    dcache_pkg::way_t             victim_r;   // way chosen at the miss

    logic [dcache_pkg::SET_W-1:0] req_set;
    logic [dcache_pkg::TAG_W-1:0] req_tag;

    assign req_set = dcache_pkg::addr_set(req_r.addr);
    assign req_tag = dcache_pkg::addr_tag(req_r.addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_CLEAR;
            clr_cnt <= '0;
        end else begin
            case (state)
                ST_CLEAR: begin
                    clr_cnt <= clr_cnt + 1'b1;
                    if (clr_cnt == dcache_pkg::LAST_SET) begin
                        state <= ST_IDLE;
                    end
                end
                ST_IDLE: begin
                    if (req_valid_i) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: state <= hit_i ? ST_IDLE : ST_REFILL;
                ST_REFILL: begin
                    if (mem_ret_valid_i) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req_valid_i) begin
            req_r <= req_i;
        end
        if (state == ST_LOOKUP && !hit_i) begin
            victim_r <= victim_i;
        end
    end

    assign ready_o = (state != ST_CLEAR);
    assign req_o   = req_r;

    // load word comes from the refill line once we are in REFILL
    assign rdata_o = (state == ST_REFILL) ? ret_word_i : hit_word_i;

    assign mem_rd_addr_o      = dcache_pkg::line_base(req_tag, req_set);
    assign mem_wr_data_o.addr = dcache_pkg::line_base(victim_tag_i, req_set);
    assign mem_wr_data_o.line = victim_line_i;

    always_comb begin
        ram_en_o     = 1'b0;
        ram_addr_o   = req_set;
        tag_we_o     = '0;
        data_we_o    = '0;
        tag_wdata_o  = '{valid: 1'b1, dirty: 1'b1, tag: req_tag};
        data_wdata_o = hit_merged_i;
        done_o       = 1'b0;
        mem_rd_o     = 1'b0;
        mem_wr_o     = 1'b0;
        case (state)
            ST_CLEAR: begin
                ram_en_o    = 1'b1;
                ram_addr_o  = clr_cnt;
                tag_we_o    = '1;   // both ways invalid
                tag_wdata_o = '0;
            end
            ST_IDLE: begin
                ram_en_o   = req_valid_i;
                ram_addr_o = dcache_pkg::addr_set(req_i.addr);
            end
            ST_LOOKUP: begin
                if (hit_i) begin
                    done_o = 1'b1;
                    if (req_r.write) begin
                        ram_en_o             = 1'b1;
                        tag_we_o[hit_way_i]  = 1'b1;   // line becomes dirty
                        data_we_o[hit_way_i] = 1'b1;
                    end
                end else begin
                    mem_rd_o = 1'b1;
                    mem_wr_o = victim_dirty_i;     // evict straight to memory
                end
            end
            ST_REFILL: begin
                if (mem_ret_valid_i) begin
                    done_o              = 1'b1;
                    ram_en_o            = 1'b1;
                    tag_we_o[victim_r]  = 1'b1;
                    data_we_o[victim_r] = 1'b1;
                    tag_wdata_o.dirty   = req_r.write;
                    data_wdata_o        = req_r.write ? ret_merged_i : mem_ret_line_i;
                end
            end
            default: ;
        endcase
    end

endmodule

/* rtl/dcache_top.sv */
module dcache_top (
    input  logic                          clk,
    input  logic                          rst,

    // processor side
    input  logic                          req_valid_i,
    input  dcache_pkg::cpu_req_t          req_i,
    output logic                          ready_o,
    output logic                          done_o,
    output logic [dcache_pkg::WORD_W-1:0] rdata_o,

    // memory side
    output logic                          mem_rd_o,
    output logic [dcache_pkg::ADDR_W-1:0] mem_rd_addr_o,
    input  logic                          mem_ret_valid_i,
    input  dcache_pkg::line_t             mem_ret_line_i,
    output logic                          mem_wr_o,
    output dcache_pkg::mem_wr_t           mem_wr_i_data_o
);

    dcache_pkg::tag_entry_t [dcache_pkg::NWAY-1:0] tag_rdata;
    dcache_pkg::line_t      [dcache_pkg::NWAY-1:0] line_rdata;

    logic                          ram_en;
    logic [dcache_pkg::SET_W-1:0]  ram_addr;
    logic [dcache_pkg::NWAY-1:0]   tag_we;
    logic [dcache_pkg::NWAY-1:0]   data_we;
    dcache_pkg::tag_entry_t        tag_wdata;
    dcache_pkg::line_t             data_wdata;

    dcache_pkg::cpu_req_t          req_q;
    dcache_pkg::way_t              victim;

    logic                          hit;
    dcache_pkg::way_t              hit_way;
    dcache_pkg::line_t             hit_line;
    logic                          victim_dirty;
    logic [dcache_pkg::TAG_W-1:0]  victim_tag;
    dcache_pkg::line_t             victim_line;

    dcache_pkg::line_t             hit_merged;
    dcache_pkg::line_t             ret_merged;
    logic [dcache_pkg::WORD_W-1:0] hit_word;
    logic [dcache_pkg::WORD_W-1:0] ret_word;

    dcache_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .req_valid_i    (req_valid_i),
        .req_i          (req_i),
        .ready_o        (ready_o),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .victim_i       (victim),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .victim_line_i  (victim_line),
        .hit_merged_i   (hit_merged),
        .ret_merged_i   (ret_merged),
        .hit_word_i     (hit_word),
        .ret_word_i     (ret_word),
        .mem_ret_valid_i(mem_ret_valid_i),
        .mem_ret_line_i (mem_ret_line_i),
        .ram_en_o       (ram_en),
        .ram_addr_o     (ram_addr),
        .tag_we_o       (tag_we),
        .data_we_o      (data_we),
        .tag_wdata_o    (tag_wdata),
        .data_wdata_o   (data_wdata),
        .req_o          (req_q),
        .done_o         (done_o),
        .rdata_o        (rdata_o),
        .mem_rd_o       (mem_rd_o),
        .mem_rd_addr_o  (mem_rd_addr_o),
        .mem_wr_o       (mem_wr_o),
        .mem_wr_data_o  (mem_wr_i_data_o)
    );

    victim_lfsr u_lfsr (
        .clk     (clk),
        .rst     (rst),
        .victim_o(victim)
    );

    way_match u_match (
        .tags_i        (tag_rdata),
        .lines_i       (line_rdata),
        .req_tag_i     (dcache_pkg::addr_tag(req_q.addr)),
        .victim_i      (victim),
        .hit_o         (hit),
        .hit_way_o     (hit_way),
        .hit_line_o    (hit_line),
        .victim_dirty_o(victim_dirty),
        .victim_tag_o  (victim_tag),
        .victim_line_o (victim_line)
    );

    // store merge on a write hit
    line_merge u_hit_merge (
        .line_i    (hit_line),
        .word_sel_i(dcache_pkg::addr_word(req_q.addr)),
        .wstrb_i   (req_q.wstrb),
        .wdata_i   (req_q.wdata),
        .line_o    (hit_merged),
        .word_o    (hit_word)
    );

    // store merge into the refill line
    line_merge u_ret_merge (
        .line_i    (mem_ret_line_i),
        .word_sel_i(dcache_pkg::addr_word(req_q.addr)),
        .wstrb_i   (req_q.wstrb),
        .wdata_i   (req_q.wdata),
        .line_o    (ret_merged),
        .word_o    (ret_word)
    );

    for (genvar w = 0; w < dcache_pkg::NWAY; w++) begin : g_way
        cache_ram #(
            .entry_t(dcache_pkg::tag_entry_t)
        ) u_tag_ram (
            .clk    (clk),
            .en_i   (ram_en),
            .we_i   (tag_we[w]),
            .addr_i (ram_addr),
            .wdata_i(tag_wdata),
            .rdata_o(tag_rdata[w])
        );

        cache_ram #(
            .entry_t(dcache_pkg::line_t)
        ) u_data_ram (
            .clk    (clk),
            .en_i   (ram_en),
            .we_i   (data_we[w]),
            .addr_i (ram_addr),
            .wdata_i(data_wdata),
            .rdata_o(line_rdata[w])
        );
    end

endmodule

/* test/dcache_mem_model.sv */
module dcache_mem_model (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rd_i,
    input  logic [dcache_pkg::ADDR_W-1:0] rd_addr_i,
    input  logic                          wr_i,
    input  dcache_pkg::mem_wr_t           wr_data_i,
    output logic                          ret_valid_o,
    output dcache_pkg::line_t             ret_line_o,
    output int                            wr_count_o
);

    localparam int DRV_DLY = 1;

    dcache_pkg::line_t             store [logic [dcache_pkg::ADDR_W-1:0]];   // written-back lines
    logic [dcache_pkg::ADDR_W-1:0] pend_addr = '0;
    int                            wait_cnt  = 0;   // 0 when no read is pending
    int                            wr_count  = 0;
    logic                          ret_valid = 1'b0;
    dcache_pkg::line_t             ret_line  = '0;

    assign ret_valid_o = ret_valid;
    assign ret_line_o  = ret_line;
    assign wr_count_o  = wr_count;

    // power-up content, a distinct word at every address
    function automatic dcache_pkg::line_t fill_line(input logic [31:0] base);
        dcache_pkg::line_t l;
        for (int i = 0; i < 4; i++) begin
            l[32*i +: 32] = ((base + 32'(4 * i)) ^ 32'h5bd1e995) * 32'h9e3779b1;
        end
        return l;
    endfunction

    always begin
        @(negedge clk);   // strobes are stable mid-cycle
        if (rst) begin
            wait_cnt = 0;
        end else begin
            if (wr_i) begin
                store[wr_data_i.addr] = wr_data_i.line;
                wr_count++;
            end
            if (rd_i) begin
                pend_addr = rd_addr_i;
                wait_cnt  = $urandom_range(1, 8);
            end
        end
        @(posedge clk);
        #DRV_DLY;
        ret_valid = 1'b0;
        if (wait_cnt > 0) begin
            wait_cnt--;
            if (wait_cnt == 0) begin
                ret_valid = 1'b1;
                ret_line  = store.exists(pend_addr) ? store[pend_addr] : fill_line(pend_addr);
            end
        end
    end

endmodule

/* test/dcache_tb.sv */
module dcache_tb;

    localparam int          N_REQ   = 400;
    localparam int          TIMEOUT = N_REQ * 12 + 300;
    localparam int          DRV_DLY = 1;
    localparam logic [31:0] SEED    = 32'h3d018cff;
    localparam int          CHK_W   = $bits(dcache_pkg::mem_wr_t);

    logic                 clk       = 1'b0;
    logic                 rst       = 1'b1;
    logic                 req_valid = 1'b0;
    dcache_pkg::cpu_req_t req       = '0;
    logic                 ready;
    logic                 done;
    logic [31:0]          rdata;
    logic                 mem_rd;
    logic [31:0]          mem_rd_addr;
    logic                 ret_valid;
    dcache_pkg::line_t    ret_line;
    logic                 mem_wr;
    dcache_pkg::mem_wr_t  mem_wr_data;
    int                   wr_count;
    int                   cycle_cnt = 0;

    logic [31:0] arch [logic [31:0]];        // words changed by stores
    bit          line_dirty [logic [31:0]];  // set once a refilled line is stored to

    always #20 clk = ~clk;

    dcache_top dut_i (
        .clk(clk), .rst(rst),
        .req_valid_i(req_valid), .req_i(req), .ready_o(ready),
        .done_o(done), .rdata_o(rdata),
        .mem_rd_o(mem_rd), .mem_rd_addr_o(mem_rd_addr),
        .mem_ret_valid_i(ret_valid), .mem_ret_line_i(ret_line),
        .mem_wr_o(mem_wr), .mem_wr_i_data_o(mem_wr_data)
    );

    dcache_mem_model mem_i (
        .clk(clk), .rst(rst),
        .rd_i(mem_rd), .rd_addr_i(mem_rd_addr),
        .wr_i(mem_wr), .wr_data_i(mem_wr_data),
        .ret_valid_o(ret_valid), .ret_line_o(ret_line), .wr_count_o(wr_count)
    );

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [CHK_W-1:0] got,
                         input logic [CHK_W-1:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
                                      name, got, exp));
        end
    endtask

    function automatic logic [31:0] model_word(input logic [31:0] a);
        return arch.exists(a) ? arch[a] : (a ^ 32'h5bd1e995) * 32'h9e3779b1;
    endfunction

    function automatic dcache_pkg::line_t model_line(input logic [31:0] base);
        dcache_pkg::line_t l;
        for (int i = 0; i < 4; i++) begin
            l[32*i +: 32] = model_word(base + 32'(4 * i));
        end
        return l;
    endfunction

    task automatic run_request(input bit wr, input logic [31:0] addr, input logic [3:0] strb,
                               input logic [31:0] data, input bit exp_hit, input bit exp_miss);
        logic [31:0] line_addr;
        logic [31:0] word;
        logic [31:0] wb_addr;
        line_addr = {addr[31:4], 4'b0};
        word      = model_word(addr);
        @(posedge clk);
        #DRV_DLY;
        req_valid = 1'b1;
        req       = '{write: wr, addr: addr, wstrb: strb, wdata: data};
        @(negedge clk);   // nothing answers in the strobe cycle
        check("ready_o", ready, 1'b1);
        check("done_o", done, 1'b0);
        check("mem_rd_o", mem_rd, 1'b0);
        check("mem_wr_o", mem_wr, 1'b0);
        @(posedge clk);
        #DRV_DLY;
        req_valid = 1'b0;
        @(negedge clk);   // lookup cycle
        if (exp_hit) check("done_o", done, 1'b1);
        if (exp_miss) check("mem_rd_o", mem_rd, 1'b1);
        if (done) begin
            check("mem_rd_o", mem_rd, 1'b0);
            check("mem_wr_o", mem_wr, 1'b0);
        end else begin
            check("mem_rd_o", mem_rd, 1'b1);
            check("mem_rd_addr_o", mem_rd_addr, line_addr);
            if (mem_wr) begin
                wb_addr = mem_wr_data.addr;
                check("mem_wr_i_data_o.addr[3:0]", wb_addr[3:0], 4'h0);
                if (!line_dirty.exists(wb_addr) || !line_dirty[wb_addr]) begin
                    stop_with_error($sformatf("line %h written back with no store since refill",
                                              wb_addr));
                end
                check("mem_wr_i_data_o.line", mem_wr_data.line, model_line(wb_addr));
                line_dirty.delete(wb_addr);
            end
            line_dirty[line_addr] = 1'b0;
            do begin
                @(negedge clk);
                check("mem_rd_o", mem_rd, 1'b0);
                check("mem_wr_o", mem_wr, 1'b0);
            end while (!done);
        end
        if (!wr) begin
            check("rdata_o", rdata, word);
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) word[8*b +: 8] = data[8*b +: 8];
            end
            arch[addr]            = word;
            line_dirty[line_addr] = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT) begin
            stop_with_error($sformatf("run did not finish within %0d cycles", TIMEOUT));
        end
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] last_line;
        bit          have_last;
        bit          wr;
        void'($urandom(SEED));
        repeat (5) @(posedge clk);
        #DRV_DLY;
        rst = 1'b0;
        @(negedge clk);
        while (!ready) begin   // cache stays silent during the clear walk
            check("mem_rd_o", mem_rd, 1'b0);
            check("mem_wr_o", mem_wr, 1'b0);
            check("done_o", done, 1'b0);
            @(negedge clk);
        end
        have_last = 1'b0;
        last_line = '0;
        for (int n = 0; n < N_REQ; n++) begin
            // 4 tags x 4 sets x 4 words plus extra reuse of the last line
            if (have_last && $urandom_range(0, 3) == 0) begin
                addr = {last_line[31:4], 2'($urandom_range(0, 3)), 2'b00};
            end else begin
                addr = {18'h2c0e1, 2'($urandom_range(0, 3)), 6'h15,
                        2'($urandom_range(0, 3)), 2'($urandom_range(0, 3)), 2'b00};
            end
            wr = (n != 0) && ($urandom_range(0, 1) == 1);
            run_request(wr, addr, 4'($urandom_range(1, 15)), $urandom,
                        have_last && (addr[31:4] == last_line[31:4]), n == 0);
            have_last = 1'b1;
            last_line = {addr[31:4], 4'b0};
        end
        if (wr_count == 0) begin
            stop_with_error("no dirty line was written back during the run");
        end else begin
            $display("%0d requests done, %0d write-backs seen", N_REQ, wr_count);
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

/* project.f */
rtl/dcache_pkg.sv
rtl/cache_ram.sv
rtl/victim_lfsr.sv
rtl/way_match.sv
rtl/line_merge.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
test/dcache_mem_model.sv
test/dcache_tb.sv

/* run.sh */
#!/bin/sh
# build the cache testbench with Verilator, run it, then scan the log
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module dcache_tb -f project.f -o dcache_sim \
    && ./obj_dir/dcache_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || exit 1
